//--- include/core_macros.svh
// Core size macros: word width, memory address widths, register count
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and instruction word
`define WORD_WIDTH 16

// 256 instruction words
`define IMEM_ADDR_WIDTH 8

// 256 data words
`define DMEM_ADDR_WIDTH 8

// Architectural registers, r0 reads as zero
`define REG_COUNT 8

// The instruction fields in decode assume these exact values:
// 4-bit opcode, three 3-bit register fields, 6- and 9-bit offsets.
// Changing them means changing the encoding too

`endif

//--- hdl/wiscPkg.sv
// Core package: data word type, register index type, opcode enum
`default_nettype none

`include "core_macros.svh"

package wiscPkg;

   // One data or instruction word
   typedef logic [`WORD_WIDTH-1:0] wordT;

   // Register file index
   typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

   // Opcode in bits 15..12, codes 12 to 15 are illegal
   typedef enum logic [3:0] {
      opNop  = 4'd0,
      opAdd  = 4'd1,
      opSub  = 4'd2,
      opAnd  = 4'd3,
      opXor  = 4'd4,
      // rd = rs + simm6
      opAddi = 4'd5,
      // rd = dmem[rs + simm6]
      opLd   = 4'd6,
      // dmem[rs + simm6] = rd
      opSt   = 4'd7,
      // Branch on rs, target pc + 1 + simm6
      opBeqz = 4'd8,
      opBnez = 4'd9,
      // Target pc + 1 + simm9
      opJmp  = 4'd10,
      opHalt = 4'd11
   } opcodeT;

endpackage

`default_nettype wire

//--- hdl/fetch.sv
// Fetch stage: program load port, instruction memory, PC, run state, IF/ID register
`default_nettype none

`include "core_macros.svh"

module fetch (
   input  wire                        clk,
   input  wire                        arstN,
   input  wire                        loadValid,
   input  wire [`IMEM_ADDR_WIDTH-1:0] loadAddr,
   input  wiscPkg::wordT              loadData,
   input  wire                        start,
   input  wire                        advance,
   input  wire                        stall,
   input  wire                        redirect,
   input  wire [`IMEM_ADDR_WIDTH-1:0] redirectPc,
   input  wire                        haltSeen,
   output logic                       loadReady,
   output logic                       running,
   output logic                       ifValid,
   output wiscPkg::wordT              ifInstr,
   output logic [`IMEM_ADDR_WIDTH-1:0] ifPc
);
   import wiscPkg::*;

   typedef enum logic {
      stIdle,
      stRun
   } stateT;

   stateT                       state;
   logic [`IMEM_ADDR_WIDTH-1:0] pc;
   logic                        issue;
   wordT                        imem [2**`IMEM_ADDR_WIDTH];

   assign loadReady = (state == stIdle);
   assign running   = (state == stRun);

   // A new word enters IF/ID only when nothing older blocks or squashes it
   assign issue = running && advance && !stall && !redirect && !haltSeen;

   // Program load only while idle
   always_ff @(posedge clk) begin
      if (loadValid && loadReady) begin
         imem[loadAddr] <= loadData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state   <= stIdle;
         pc      <= '0;
         ifValid <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               if (start) begin
                  state <= stRun;
                  pc    <= '0;
               end
            end
            stRun: begin
               if (advance) begin
                  if (haltSeen) begin
                     // Stop issuing and let the rest of the pipe drain
                     state   <= stIdle;
                     ifValid <= 1'b0;
                  end else if (redirect) begin
                     pc      <= redirectPc;
                     ifValid <= 1'b0;
                  end else if (!stall) begin
                     pc      <= pc + 1'b1;
                     ifValid <= 1'b1;
                  end
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         ifInstr <= imem[pc];
         ifPc    <= pc;
      end
   end

   // Nothing left in the pipe may redirect or halt while fetch is idle
   aIdleQuiet: assert property (@(posedge clk) disable iff (!arstN)
      loadReady |-> !redirect && !haltSeen);

endmodule

`default_nettype wire

//--- hdl/decode.sv
// Decode stage: field split, register file, hazard stall, illegal opcode check, ID/EX register
`default_nettype none

`include "core_macros.svh"

module decode (
   input  wire                         clk,
   input  wire                         arstN,
   input  wire                         advance,
   input  wire                         flush,
   input  wire                         ifValid,
   input  wiscPkg::wordT               ifInstr,
   input  wire  [`IMEM_ADDR_WIDTH-1:0] ifPc,
   input  wire                         wbEnable,
   input  wiscPkg::regAddrT            wbDest,
   input  wiscPkg::wordT               wbData,
   input  wiscPkg::regAddrT            exDest,
   input  wire                         exWrites,
   output logic                        stall,
   output logic                        idValid,
   output wiscPkg::opcodeT             idOp,
   output wiscPkg::regAddrT            idDest,
   output logic                        idWrites,
   output wiscPkg::wordT               idA,
   output wiscPkg::wordT               idB,
   output wiscPkg::wordT               idImm,
   output logic [`IMEM_ADDR_WIDTH-1:0] idPc,
   output logic                        idIllegal
);
   import wiscPkg::*;

   wordT       regs [`REG_COUNT];
   logic [3:0] opRaw;
   regAddrT    rd;
   regAddrT    rs;
   regAddrT    rt;
   regAddrT    bIdx;
   opcodeT     op;
   logic       illegal;
   logic       readsA;
   logic       readsB;
   logic       storeOp;
   logic       writes;
   wordT       imm;
   wordT       aVal;
   wordT       bVal;
   logic       aBusy;
   logic       bBusy;
   logic       take;

   assign opRaw = ifInstr[15:12];
   assign rd    = ifInstr[11:9];
   assign rs    = ifInstr[8:6];
   assign rt    = ifInstr[5:3];

   always_comb begin
      op      = opHalt;
      illegal = 1'b0;
      readsA  = 1'b0;
      readsB  = 1'b0;
      storeOp = 1'b0;
      writes  = 1'b0;
      imm     = {{(`WORD_WIDTH-6){ifInstr[5]}}, ifInstr[5:0]};
      case (opRaw)
         opNop: op = opNop;
         opAdd, opSub, opAnd, opXor: begin
            op     = opcodeT'(opRaw);
            readsA = 1'b1;
            readsB = 1'b1;
            writes = 1'b1;
         end
         opAddi, opLd: begin
            op     = opcodeT'(opRaw);
            readsA = 1'b1;
            writes = 1'b1;
         end
         opSt: begin
            op      = opSt;
            readsA  = 1'b1;
            readsB  = 1'b1;
            storeOp = 1'b1;
         end
         opBeqz, opBnez: begin
            op     = opcodeT'(opRaw);
            readsA = 1'b1;
         end
         opJmp: begin
            op  = opJmp;
            imm = {{(`WORD_WIDTH-9){ifInstr[8]}}, ifInstr[8:0]};
         end
         opHalt: op = opHalt;
         // Illegal codes travel as halt
         default: illegal = 1'b1;
      endcase
   end

   // Store data comes from rd, everything else reads rt
   assign bIdx = storeOp ? rd : rt;

   // Register read, a write in the same cycle passes straight through
   always_comb begin
      aVal = regs[rs];
      bVal = regs[bIdx];
      if (wbEnable && wbDest == rs) aVal = wbData;
      if (wbEnable && wbDest == bIdx) bVal = wbData;
      if (rs == '0) aVal = '0;
      if (bIdx == '0) bVal = '0;
   end

   assign aBusy = (idValid && idWrites && idDest == rs) || (exWrites && exDest == rs);
   assign bBusy = (idValid && idWrites && idDest == bIdx) || (exWrites && exDest == bIdx);
   assign stall = ifValid && ((readsA && aBusy) || (readsB && bBusy));

   assign take = ifValid && !stall && !flush;

   always_ff @(posedge clk) begin
      if (wbEnable) begin
         regs[wbDest] <= wbData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         idValid  <= 1'b0;
         idWrites <= 1'b0;
      end else if (advance) begin
         idValid  <= take;
         idWrites <= take && writes && (rd != '0);
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         idOp      <= op;
         idDest    <= rd;
         idA       <= aVal;
         idB       <= bVal;
         idImm     <= imm;
         idPc      <= ifPc;
         idIllegal <= illegal;
      end
   end

   // Writeback never targets r0
   aNoR0Write: assert property (@(posedge clk) disable iff (!arstN)
      wbEnable |-> wbDest != '0);

endmodule

`default_nettype wire

//--- hdl/execute.sv
// Execute stage: ALU, branch and jump resolution, halt detection, EX/MEM register
`default_nettype none

`include "core_macros.svh"

module execute (
   input  wire                         clk,
   input  wire                         arstN,
   input  wire                         advance,
   input  wire                         idValid,
   input  wiscPkg::opcodeT             idOp,
   input  wiscPkg::regAddrT            idDest,
   input  wire                         idWrites,
   input  wiscPkg::wordT               idA,
   input  wiscPkg::wordT               idB,
   input  wiscPkg::wordT               idImm,
   input  wire  [`IMEM_ADDR_WIDTH-1:0] idPc,
   input  wire                         idIllegal,
   output logic                        redirect,
   output logic [`IMEM_ADDR_WIDTH-1:0] redirectPc,
   output logic                        haltSeen,
   output logic                        illegalSeen,
   output logic                        exValid,
   output wiscPkg::opcodeT             exOp,
   output wiscPkg::regAddrT            exDest,
   output logic                        exWrites,
   output wiscPkg::wordT               exResult,
   output wiscPkg::wordT               exStoreData
);
   import wiscPkg::*;

   wordT aluOut;
   logic taken;

   always_comb begin
      aluOut = '0;
      taken  = 1'b0;
      case (idOp)
         opAdd:  aluOut = idA + idB;
         opSub:  aluOut = idA - idB;
         opAnd:  aluOut = idA & idB;
         opXor:  aluOut = idA ^ idB;
         // Sum doubles as the memory address
         opAddi, opLd, opSt: aluOut = idA + idImm;
         opBeqz: taken = (idA == '0);
         opBnez: taken = (idA != '0);
         opJmp:  taken = 1'b1;
         default: aluOut = '0;
      endcase
   end

   // Target wraps within the instruction memory
   assign redirectPc  = idPc + 1'b1 + idImm[`IMEM_ADDR_WIDTH-1:0];
   assign redirect    = idValid && taken;
   assign haltSeen    = idValid && (idOp == opHalt);
   assign illegalSeen = haltSeen && idIllegal;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exValid  <= 1'b0;
         exWrites <= 1'b0;
      end else if (advance) begin
         exValid  <= idValid;
         exWrites <= idValid && idWrites;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         exOp        <= idOp;
         exDest      <= idDest;
         exResult    <= aluOut;
         exStoreData <= idB;
      end
   end

endmodule

`default_nettype wire

//--- hdl/memWriteback.sv
// Memory and writeback stage: data memory, writeback mux, retire trace register
`default_nettype none

`include "core_macros.svh"

module memWriteback (
   input  wire                         clk,
   input  wire                         arstN,
   input  wire                         exValid,
   input  wiscPkg::opcodeT             exOp,
   input  wiscPkg::regAddrT            exDest,
   input  wire                         exWrites,
   input  wiscPkg::wordT               exResult,
   input  wiscPkg::wordT               exStoreData,
   input  wire                         traceReady,
   output logic                        advance,
   output logic                        traceValid,
   output logic                        traceStore,
   output wiscPkg::regAddrT            traceDest,
   output logic [`DMEM_ADDR_WIDTH-1:0] traceAddr,
   output wiscPkg::wordT               traceData,
   output logic                        wbEnable,
   output wiscPkg::regAddrT            wbDest,
   output wiscPkg::wordT               wbData
);
   import wiscPkg::*;

   wordT                        dmem [2**`DMEM_ADDR_WIDTH];
   logic [`DMEM_ADDR_WIDTH-1:0] addr;
   logic                        isStore;
   logic                        isLoad;
   logic                        entry;

   assign addr    = exResult[`DMEM_ADDR_WIDTH-1:0];
   assign isStore = exValid && (exOp == opSt);
   assign isLoad  = exValid && (exOp == opLd);
   // exWrites already excludes r0 and bubbles
   assign entry   = isStore || exWrites;

   // Held trace entry freezes the whole pipe
   assign advance = !(traceValid && !traceReady);

   assign wbEnable = traceValid && traceReady && !traceStore;
   assign wbDest   = traceDest;
   assign wbData   = traceData;

   always_ff @(posedge clk) begin
      if (advance && isStore) begin
         dmem[addr] <= exStoreData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         traceValid <= 1'b0;
      end else if (advance) begin
         traceValid <= entry;
      end
   end

   // Stores report no destination and register writes no address
   always_ff @(posedge clk) begin
      if (advance && entry) begin
         traceStore <= isStore;
         traceDest  <= isStore ? regAddrT'(0) : exDest;
         traceAddr  <= (isStore || isLoad) ? addr : '0;
         traceData  <= isStore ? exStoreData : (isLoad ? dmem[addr] : exResult);
      end
   end

   // The EX/MEM entry waits upstream while the trace is held
   aExHold: assert property (@(posedge clk) disable iff (!arstN)
      !advance |=> $stable({exValid, exWrites, exOp}));

endmodule

`default_nettype wire

//--- hdl/proc.sv
// Processor top: four pipeline stages, busy and sticky error flag
`default_nettype none

`include "core_macros.svh"

module proc (
   input  wire                         clk,
   input  wire                         arstN,
   input  wire                         loadValid,
   input  wire  [`IMEM_ADDR_WIDTH-1:0] loadAddr,
   input  wiscPkg::wordT               loadData,
   input  wire                         start,
   input  wire                         traceReady,
   output logic                        loadReady,
   output logic                        busy,
   output logic                        err,
   output logic                        traceValid,
   output logic                        traceStore,
   output wiscPkg::regAddrT            traceDest,
   output logic [`DMEM_ADDR_WIDTH-1:0] traceAddr,
   output wiscPkg::wordT               traceData
);
   import wiscPkg::*;

   logic                        advance;
   logic                        stall;
   logic                        flush;
   logic                        redirect;
   logic [`IMEM_ADDR_WIDTH-1:0] redirectPc;
   logic                        haltSeen;
   logic                        illegalSeen;
   logic                        running;
   logic                        ifValid;
   wordT                        ifInstr;
   logic [`IMEM_ADDR_WIDTH-1:0] ifPc;
   logic                        idValid;
   opcodeT                      idOp;
   regAddrT                     idDest;
   logic                        idWrites;
   wordT                        idA;
   wordT                        idB;
   wordT                        idImm;
   logic [`IMEM_ADDR_WIDTH-1:0] idPc;
   logic                        idIllegal;
   logic                        exValid;
   opcodeT                      exOp;
   regAddrT                     exDest;
   logic                        exWrites;
   wordT                        exResult;
   wordT                        exStoreData;
   logic                        wbEnable;
   regAddrT                     wbDest;
   wordT                        wbData;

   // A halt also squashes whatever was fetched behind it
   assign flush = redirect || haltSeen;
   assign busy  = running || ifValid || idValid || exValid || traceValid;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         err <= 1'b0;
      end else if (start && loadReady) begin
         err <= 1'b0;
      end else if (illegalSeen) begin
         err <= 1'b1;
      end
   end

   fetch fetch0 (
      .clk(clk), .arstN(arstN), .loadValid(loadValid), .loadAddr(loadAddr),
      .loadData(loadData), .start(start), .advance(advance), .stall(stall),
      .redirect(redirect), .redirectPc(redirectPc), .haltSeen(haltSeen),
      .loadReady(loadReady), .running(running), .ifValid(ifValid),
      .ifInstr(ifInstr), .ifPc(ifPc)
   );

   decode decode0 (
      .clk(clk), .arstN(arstN), .advance(advance), .flush(flush),
      .ifValid(ifValid), .ifInstr(ifInstr), .ifPc(ifPc),
      .wbEnable(wbEnable), .wbDest(wbDest), .wbData(wbData),
      .exDest(exDest), .exWrites(exWrites), .stall(stall),
      .idValid(idValid), .idOp(idOp), .idDest(idDest), .idWrites(idWrites),
      .idA(idA), .idB(idB), .idImm(idImm), .idPc(idPc), .idIllegal(idIllegal)
   );

   execute execute0 (
      .clk(clk), .arstN(arstN), .advance(advance), .idValid(idValid),
      .idOp(idOp), .idDest(idDest), .idWrites(idWrites), .idA(idA), .idB(idB),
      .idImm(idImm), .idPc(idPc), .idIllegal(idIllegal), .redirect(redirect),
      .redirectPc(redirectPc), .haltSeen(haltSeen), .illegalSeen(illegalSeen),
      .exValid(exValid), .exOp(exOp), .exDest(exDest), .exWrites(exWrites),
      .exResult(exResult), .exStoreData(exStoreData)
   );

   memWriteback memWriteback0 (
      .clk(clk), .arstN(arstN), .exValid(exValid), .exOp(exOp),
      .exDest(exDest), .exWrites(exWrites), .exResult(exResult),
      .exStoreData(exStoreData), .traceReady(traceReady), .advance(advance),
      .traceValid(traceValid), .traceStore(traceStore), .traceDest(traceDest),
      .traceAddr(traceAddr), .traceData(traceData), .wbEnable(wbEnable),
      .wbDest(wbDest), .wbData(wbData)
   );

endmodule

`default_nettype wire

//--- test/procTb.sv
// Testbench for proc: clock, reset, watchdog, check task, directed program tests
`default_nettype none

module procTb;
   import wiscPkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 4;
   // Cycle budget per directed test including the program load
   localparam int ARITH_CYCLES  = 150;
   localparam int HAZARD_CYCLES = 150;
   localparam int BRANCH_CYCLES = 200;
   localparam int MEM_CYCLES    = 150;
   localparam int BP_CYCLES     = 300;
   localparam int HALT_CYCLES   = 200;
   localparam int TOTAL_CYCLES  = ARITH_CYCLES + HAZARD_CYCLES + BRANCH_CYCLES +
                                  MEM_CYCLES + BP_CYCLES + HALT_CYCLES;

   logic        clk;
   logic        arstN;
   logic        loadValid;
   logic [7:0]  loadAddr;
   logic [15:0] loadData;
   logic        start;
   logic        traceReady;
   logic        loadReady;
   logic        busy;
   logic        err;
   logic        traceValid;
   logic        traceStore;
   logic [2:0]  traceDest;
   logic [7:0]  traceAddr;
   logic [15:0] traceData;

   // Program words and expected trace entries {store, dest, addr, data}
   logic [15:0] prog [$];
   logic [27:0] expected [$];
   integer      seed = 89;
   int          checks = 0;
   int          errors = 0;

   proc UUT (
      .clk(clk), .arstN(arstN), .loadValid(loadValid), .loadAddr(loadAddr),
      .loadData(loadData), .start(start), .traceReady(traceReady),
      .loadReady(loadReady), .busy(busy), .err(err), .traceValid(traceValid),
      .traceStore(traceStore), .traceDest(traceDest), .traceAddr(traceAddr),
      .traceData(traceData)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // Instruction encoders
   function automatic logic [15:0] rInstr(input opcodeT op, input int rd, input int rs,
                                          input int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   function automatic logic [15:0] iInstr(input opcodeT op, input int rd, input int rs,
                                          input int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic logic [15:0] jInstr(input int offset);
      return {opJmp, 3'b000, offset[8:0]};
   endfunction

   function automatic logic [15:0] haltInstr();
      return {opHalt, 12'h000};
   endfunction

   task automatic writeEntry(input int dest, input logic [15:0] data);
      expected.push_back({1'b0, dest[2:0], 8'h00, data});
   endtask

   task automatic ldEntry(input int dest, input logic [7:0] addr, input logic [15:0] data);
      expected.push_back({1'b0, dest[2:0], addr, data});
   endtask

   task automatic stEntry(input logic [7:0] addr, input logic [15:0] data);
      expected.push_back({1'b1, 3'd0, addr, data});
   endtask

   // Writes prog plus a trailing nop into instruction memory from address 0
   task automatic loadProgram();
      prog.push_back(16'h0000);
      for (int i = 0; i < prog.size(); i++) begin
         loadValid = 1'b1;
         loadAddr  = i[7:0];
         loadData  = prog[i];
         while (!loadReady) begin
            @(posedge clk);
            #1;
         end
         @(posedge clk);
         #1;
      end
      loadValid = 1'b0;
      prog.delete();
   endtask

   task automatic compareEntry();
      logic [27:0] exp;
      if (expected.size() == 0) begin
         errors++;
         $display("Unexpected trace entry retired with nothing left to expect");
      end else begin
         exp = expected.pop_front();
         check("traceStore", traceStore, exp[27]);
         check("traceDest", traceDest, exp[26:24]);
         check("traceAddr", traceAddr, exp[23:16]);
         check("traceData", traceData, exp[15:0]);
      end
   endtask

   // Starts the loaded program and checks accepted entries until the core is idle
   task automatic runProgram(input bit randomReady, input bit expErr);
      int randVal;
      bit done;
      traceReady = 1'b1;
      start      = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      done  = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (!busy) begin
            done = 1'b1;
         end else begin
            // Entry is taken at the coming rising edge
            if (traceValid && traceReady) begin
               compareEntry();
            end
            @(posedge clk);
            #1;
            if (randomReady) begin
               randVal    = $random(seed);
               traceReady = randVal[0];
            end
         end
      end
      @(posedge clk);
      #1;
      traceReady = 1'b1;
      if (expected.size() != 0) begin
         errors++;
         $display("Core went idle with %0d trace entries still expected", expected.size());
         expected.delete();
      end
      check("busy", busy, 0);
      check("err", err, expErr);
      check("loadReady", loadReady, 1);
   endtask

   // Shared by the arithmetic and back-pressure tests
   task automatic arithmeticProgram();
      prog.push_back(iInstr(opAddi, 1, 0, 5));
      prog.push_back(iInstr(opAddi, 2, 0, -3));
      prog.push_back(rInstr(opAdd, 3, 1, 2));
      prog.push_back(rInstr(opSub, 4, 1, 2));
      prog.push_back(rInstr(opAnd, 5, 1, 2));
      prog.push_back(rInstr(opXor, 6, 1, 2));
      // Write to r0 is dropped
      prog.push_back(iInstr(opAddi, 0, 1, 7));
      prog.push_back(rInstr(opAdd, 7, 0, 1));
      prog.push_back(haltInstr());
      writeEntry(1, 16'h0005);
      writeEntry(2, 16'hfffd);
      writeEntry(3, 16'h0002);
      writeEntry(4, 16'h0008);
      writeEntry(5, 16'h0005);
      writeEntry(6, 16'hfff8);
      writeEntry(7, 16'h0005);
      loadProgram();
   endtask

   task automatic basicAluOps();
      $display("Test: arithmetic");
      arithmeticProgram();
      runProgram(1'b0, 1'b0);
   endtask

   task automatic dependentChains();
      $display("Test: hazards");
      prog.push_back(iInstr(opAddi, 1, 0, 10));
      prog.push_back(iInstr(opAddi, 2, 1, 1));
      prog.push_back(iInstr(opAddi, 3, 0, 3));
      prog.push_back(rInstr(opAdd, 4, 2, 3));
      prog.push_back(iInstr(opAddi, 5, 0, 1));
      prog.push_back(iInstr(opAddi, 6, 0, 2));
      prog.push_back(rInstr(opSub, 7, 4, 5));
      prog.push_back(rInstr(opXor, 1, 7, 6));
      prog.push_back(haltInstr());
      writeEntry(1, 16'h000a);
      writeEntry(2, 16'h000b);
      writeEntry(3, 16'h0003);
      writeEntry(4, 16'h000e);
      writeEntry(5, 16'h0001);
      writeEntry(6, 16'h0002);
      writeEntry(7, 16'h000d);
      writeEntry(1, 16'h000f);
      loadProgram();
      runProgram(1'b0, 1'b0);
   endtask

   task automatic branchAndLoop();
      $display("Test: branches and jumps");
      prog.push_back(iInstr(opAddi, 1, 0, 3));
      prog.push_back(iInstr(opAddi, 2, 0, 0));
      // Taken branch skips the two r7 writes
      prog.push_back(iInstr(opBeqz, 0, 2, 2));
      prog.push_back(iInstr(opAddi, 7, 0, 31));
      prog.push_back(iInstr(opAddi, 7, 0, 30));
      prog.push_back(iInstr(opBnez, 0, 0, 3));
      // Three passes through the loop body at 6
      prog.push_back(iInstr(opAddi, 2, 2, 4));
      prog.push_back(iInstr(opAddi, 1, 1, -1));
      prog.push_back(iInstr(opBeqz, 0, 1, 1));
      prog.push_back(jInstr(-4));
      prog.push_back(iInstr(opAddi, 3, 2, 0));
      prog.push_back(haltInstr());
      prog.push_back(iInstr(opAddi, 7, 0, 29));
      writeEntry(1, 16'h0003);
      writeEntry(2, 16'h0000);
      writeEntry(2, 16'h0004);
      writeEntry(1, 16'h0002);
      writeEntry(2, 16'h0008);
      writeEntry(1, 16'h0001);
      writeEntry(2, 16'h000c);
      writeEntry(1, 16'h0000);
      writeEntry(3, 16'h000c);
      loadProgram();
      runProgram(1'b0, 1'b0);
   endtask

   task automatic storeThenLoad();
      $display("Test: loads and stores");
      prog.push_back(iInstr(opAddi, 1, 0, 20));
      prog.push_back(iInstr(opAddi, 2, 0, -7));
      prog.push_back(iInstr(opSt, 2, 1, 3));
      prog.push_back(iInstr(opSt, 1, 1, -4));
      prog.push_back(iInstr(opLd, 3, 0, 23));
      prog.push_back(iInstr(opLd, 4, 1, -4));
      prog.push_back(rInstr(opAdd, 5, 3, 4));
      prog.push_back(haltInstr());
      writeEntry(1, 16'h0014);
      writeEntry(2, 16'hfff9);
      stEntry(8'h17, 16'hfff9);
      stEntry(8'h10, 16'h0014);
      ldEntry(3, 8'h17, 16'hfff9);
      ldEntry(4, 8'h10, 16'h0014);
      writeEntry(5, 16'h000d);
      loadProgram();
      runProgram(1'b0, 1'b0);
   endtask

   task automatic randomTraceStall();
      $display("Test: trace back-pressure");
      arithmeticProgram();
      runProgram(1'b1, 1'b0);
   endtask

   task automatic illegalAndHalt();
      $display("Test: halt and illegal opcode");
      prog.push_back(iInstr(opAddi, 1, 0, 6));
      prog.push_back(16'hc000);
      prog.push_back(iInstr(opAddi, 2, 0, 9));
      prog.push_back(haltInstr());
      writeEntry(1, 16'h0006);
      loadProgram();
      runProgram(1'b0, 1'b1);
      // Next start clears err
      prog.push_back(iInstr(opAddi, 1, 0, 1));
      prog.push_back(haltInstr());
      prog.push_back(iInstr(opAddi, 2, 0, 2));
      writeEntry(1, 16'h0001);
      loadProgram();
      runProgram(1'b0, 1'b0);
   endtask

   initial begin
      arstN      = 1'b0;
      loadValid  = 1'b0;
      loadAddr   = '0;
      loadData   = '0;
      start      = 1'b0;
      traceReady = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arstN = 1'b1;
      @(posedge clk);
      #1;
      basicAluOps();
      dependentChains();
      branchAndLoop();
      storeThenLoad();
      randomTraceStall();
      illegalAndHalt();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(CLK_PERIOD * (RESET_CYCLES + TOTAL_CYCLES));
      $display("Timeout: the core did not finish its programs in time");
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- proc.f
+incdir+include
hdl/wiscPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memWriteback.sv
hdl/proc.sv
test/procTb.sv

//--- Bender.yml
package:
  name: proc

sources:
  - include_dirs:
      - include
    files:
      - hdl/wiscPkg.sv
      - hdl/fetch.sv
      - hdl/decode.sv
      - hdl/execute.sv
      - hdl/memWriteback.sv
      - hdl/proc.sv
  - target: test
    files:
      - test/procTb.sv
